// File: sources.f
design/servo_pkg.sv
design/servo_reg_port.sv
design/trig_cmd_master.sv
design/beam_bank.sv
design/servo_sequencer.sv
design/rate_servo_top.sv
tests/trig_target_model.sv
tests/tb_rate_servo.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the rate servo testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_rate_servo -f sources.f
out=$(./obj_dir/Vtb_rate_servo)
echo "$out"
if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// File: tests/tb_rate_servo.sv
`timescale 1ns/100ps

module tb_rate_servo;
    import servo_pkg::*;

    localparam int NBEAMS       = 2;
    localparam int START_THRESH = 3500;
    localparam int TARGET_COUNT = 100;
    localparam int COUNT_MARGIN = 10;   // Dead band 90 to 110
    localparam int KP_STEP      = 1;
    localparam int BOOT_CYCLES  = 31;
    localparam int NROWS        = 6;
    // Start, four polls, three commands per beam and commit, each at most 12 cycles
    localparam int ROUND_CYCLES = (6 + 3 * NBEAMS) * 12 + NBEAMS;
    localparam int CYCLE_LIMIT  = (NROWS + 1) * ROUND_CYCLES + BOOT_CYCLES + 300;
    localparam logic [ADDR_W-1:0] TH_SEL  = ADDR_W'(1 << SEL_THRESH_BIT);
    localparam logic [ADDR_W-1:0] CNT_SEL = ADDR_W'(1 << SEL_COUNT_BIT);

    // Counts per round and the threshold step each one calls for
    localparam logic [31:0] ROW_COUNT [NROWS][NBEAMS] = '{
        '{32'd150, 32'd40},     // Far outside
        '{32'd111, 32'd89},     // One past each edge
        '{32'd110, 32'd90},     // On the edges
        '{32'd90,  32'd110},
        '{32'd100, 32'd105},    // Inside
        '{32'd0,   32'd4000}
    };
    localparam int ROW_STEP [NROWS][NBEAMS] = '{
        '{1, -1}, '{1, -1}, '{0, 0}, '{0, 0}, '{0, 0}, '{-1, 1}
    };

    logic                wb_clk_i, reset_i, wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
    logic [ADDR_W-1:0]   wb_adr_i, cmd_adr_o, log_adr, adr_q;
    logic [DATA_W-1:0]   wb_dat_i, wb_dat_o, cmd_dat_o, cmd_dat_i, dat_q;
    logic                cmd_cyc_o, cmd_we_o, cmd_ack_i;
    logic                hold, log_valid, log_we, we_q;
    logic [DATA_W-1:0]   log_wdat, log_rdat;
    logic [31:0]         counts [NBEAMS];
    logic [THRESH_W-1:0] exp_th [NBEAMS];   // Thresholds the DUT should send next
    logic                cyc_q = 1'b0;
    logic                ack_q = 1'b0;
    int                  errors = 0;
    int                  checks = 0;
    int                  cycles = 0;

    rate_servo_top #(
        .NBEAMS(NBEAMS), .START_THRESH(START_THRESH), .TARGET_COUNT(TARGET_COUNT),
        .COUNT_MARGIN(COUNT_MARGIN), .KP_STEP(KP_STEP), .BOOT_CYCLES(BOOT_CYCLES)
    ) DUT (.*);

    trig_target_model #(.NBEAMS(NBEAMS), .SEED(32'h0e45_9dd7)) u_target (
        .wb_clk_i, .reset_i, .hold_i(hold), .counts_i(counts),
        .cmd_cyc_i(cmd_cyc_o), .cmd_we_i(cmd_we_o), .cmd_adr_i(cmd_adr_o),
        .cmd_dat_i(cmd_dat_o), .cmd_ack_o(cmd_ack_i), .cmd_dat_o(cmd_dat_i),
        .log_valid_o(log_valid), .log_we_o(log_we), .log_adr_o(log_adr),
        .log_wdat_o(log_wdat), .log_rdat_o(log_rdat)
    );

    initial wb_clk_i = 1'b0;
    always #20 wb_clk_i = ~wb_clk_i;

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    // Waits for the next acked command in the model log
    task automatic next_cmd();
        @(posedge wb_clk_i);
        while (!log_valid) @(posedge wb_clk_i);
    endtask

    task automatic expect_cmd(input string what, input logic we,
                              input logic [ADDR_W-1:0] adr, input logic [DATA_W-1:0] dat);
        next_cmd();
        check_value({what, " direction"}, 64'(log_we), 64'(we));
        check_value({what, " address"}, 64'(log_adr), 64'(adr));
        if (we) check_value({what, " data"}, 64'(log_wdat), 64'(dat));
    endtask

    // Status reads until the model answers count done, nothing else in between
    task automatic wait_count_done();
        int polls;
        polls = 0;
        next_cmd();
        while (!log_we && log_adr == CMD_ADDR_CONTROL && !log_rdat[0] && polls < 8) begin
            polls++;
            next_cmd();
        end
        if (log_we || log_adr != CMD_ADDR_CONTROL || !log_rdat[0]) begin
            errors++;
            $display("At %0t the DUT stopped polling before the count was done", $time);
        end
    endtask

    task automatic write_thresholds();
        for (int b = 0; b < NBEAMS; b++)
            expect_cmd("threshold write", 1'b1, CMD_BASE_THRESH + ADDR_W'(b), DATA_W'(exp_th[b]));
        for (int b = 0; b < NBEAMS; b++)
            expect_cmd("load enable", 1'b1, CMD_BASE_LOAD + ADDR_W'(b), LOAD_ENABLE);
        expect_cmd("commit", 1'b1, CMD_ADDR_CONTROL, CTRL_COMMIT);
    endtask

    // One upstream access; ack is due on the second edge after the accepting one
    task automatic upstream_access(input logic we, input logic [ADDR_W-1:0] adr,
                                   output logic [DATA_W-1:0] data);
        int edges;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= 32'h0003_ffff;   // Would move a threshold if writes had effect
        edges = 1;
        @(posedge wb_clk_i);
        while (!wb_ack_o && edges < 10) begin
            @(posedge wb_clk_i);
            edges++;
        end
        check_value("upstream ack latency", 64'(edges), 64'd3);
        data = wb_dat_o;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(posedge wb_clk_i);
    endtask

    ////////////////////////////////////////
    // Command bus stability
    ////////////////////////////////////////
    always @(posedge wb_clk_i) begin
        if (!reset_i && cyc_q) begin
            if (ack_q) check_value("cyc low after ack", 64'(cmd_cyc_o), 64'd0);
            else if (cmd_cyc_o) check_value("request held", 64'({cmd_we_o, cmd_adr_o, cmd_dat_o}),
                                            64'({we_q, adr_q, dat_q}));
        end
        cyc_q <= cmd_cyc_o;
        ack_q <= cmd_ack_i;
        we_q  <= cmd_we_o;
        adr_q <= cmd_adr_o;
        dat_q <= cmd_dat_o;
    end

    always @(posedge wb_clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles, the servo loop made no progress", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        logic [DATA_W-1:0] rd;
        reset_i  = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        hold     = 1'b0;
        for (int b = 0; b < NBEAMS; b++) begin
            counts[b] = '0;
            exp_th[b] = THRESH_W'(START_THRESH);
        end
        repeat (10) @(posedge wb_clk_i);
        reset_i <= 1'b0;

        write_thresholds();   // Boot pushes the start thresholds
        for (int r = 0; r < NROWS; r++) begin
            for (int b = 0; b < NBEAMS; b++) counts[b] <= ROW_COUNT[r][b];
            expect_cmd("start", 1'b1, CMD_ADDR_CONTROL, CTRL_START);
            wait_count_done();
            for (int b = 0; b < NBEAMS; b++)
                expect_cmd("count read", 1'b0, CMD_BASE_THRESH + ADDR_W'(b), '0);
            for (int b = 0; b < NBEAMS; b++)   // Wraps in 18 bits
                exp_th[b] = exp_th[b] + THRESH_W'(ROW_STEP[r][b] * KP_STEP);
            write_thresholds();
        end

        // Park the next start write so nothing moves during readback
        hold <= 1'b1;
        for (int b = 0; b < NBEAMS; b++) begin
            upstream_access(1'b0, TH_SEL | ADDR_W'(b), rd);
            check_value("threshold readback", 64'(rd), 64'(exp_th[b]));
            upstream_access(1'b0, CNT_SEL | ADDR_W'(b), rd);
            check_value("count readback", 64'(rd), 64'(ROW_COUNT[NROWS-1][b]));
        end
        upstream_access(1'b0, '0, rd);
        check_value("step readback", 64'(rd), 64'(KP_STEP));
        upstream_access(1'b0, TH_SEL | ADDR_W'(NBEAMS), rd);
        check_value("threshold readback past last beam", 64'(rd), 64'd0);
        upstream_access(1'b0, CNT_SEL | ADDR_W'(NBEAMS), rd);
        check_value("count readback past last beam", 64'(rd), 64'd0);
        upstream_access(1'b1, TH_SEL, rd);
        upstream_access(1'b0, TH_SEL, rd);
        check_value("threshold after upstream write", 64'(rd), 64'(exp_th[0]));

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) $display("ALL TESTS PASSED");
        else $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: tests/trig_target_model.sv
`timescale 1ns/100ps

module trig_target_model #(
    parameter int          NBEAMS = 2,
    parameter logic [31:0] SEED   = 32'h0e45_9dd7
) (
    input  logic                         wb_clk_i,
    input  logic                         reset_i,
    input  logic                         hold_i,                // Withhold every ack
    input  logic [31:0]                  counts_i [NBEAMS],     // Counts for this round
    // Command bus from the DUT
    input  logic                         cmd_cyc_i,
    input  logic                         cmd_we_i,
    input  logic [servo_pkg::ADDR_W-1:0] cmd_adr_i,
    input  logic [servo_pkg::DATA_W-1:0] cmd_dat_i,
    output logic                         cmd_ack_o,
    output logic [servo_pkg::DATA_W-1:0] cmd_dat_o,
    // Transaction log, one pulse per ack
    output logic                         log_valid_o,
    output logic                         log_we_o,
    output logic [servo_pkg::ADDR_W-1:0] log_adr_o,
    output logic [servo_pkg::DATA_W-1:0] log_wdat_o,
    output logic [servo_pkg::DATA_W-1:0] log_rdat_o
);
    import servo_pkg::*;

    logic [31:0] rng;          // xorshift state
    logic [31:0] rng_next;
    logic [2:0]  wait_cnt;     // Ack delay left for the current request
    int          polls_left;   // Status reads until count done

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    assign rng_next = xorshift32(rng);

    initial begin
        cmd_ack_o   = 1'b0;
        cmd_dat_o   = '0;
        log_valid_o = 1'b0;
    end

    ////////////////////////////////////////
    // Register block response
    ////////////////////////////////////////
    always @(posedge wb_clk_i) begin : respond
        logic [DATA_W-1:0] rdat;
        int                idx;
        rdat = '0;
        idx  = int'(cmd_adr_i) - int'(CMD_BASE_THRESH);   // Beam of a count read
        cmd_ack_o   <= 1'b0;
        log_valid_o <= 1'b0;
        if (reset_i) begin
            rng        <= SEED;
            wait_cnt   <= SEED[2:0];
            polls_left <= 0;
        end else if (cmd_cyc_i && !cmd_ack_o && !hold_i) begin
            if (wait_cnt != 3'd0) begin
                wait_cnt <= wait_cnt - 3'd1;   // Back-pressure
            end else begin
                rng      <= rng_next;
                wait_cnt <= rng_next[2:0];     // Delay of the next request, 0 to 7
                if (!cmd_we_i && cmd_adr_i == CMD_ADDR_CONTROL) begin
                    rdat[0] = (polls_left <= 1);   // Count done
                    if (polls_left > 1) polls_left <= polls_left - 1;
                end else if (!cmd_we_i && idx >= 0 && idx < NBEAMS) begin
                    rdat = counts_i[idx];
                end else if (cmd_we_i && cmd_adr_i == CMD_ADDR_CONTROL &&
                             cmd_dat_i == CTRL_START) begin
                    polls_left <= int'(rng_next[9:8]) + 1;   // Done on read 1 to 4
                end
                cmd_ack_o   <= 1'b1;
                cmd_dat_o   <= rdat;
                log_valid_o <= 1'b1;
                log_we_o    <= cmd_we_i;
                log_adr_o   <= cmd_adr_i;
                log_wdat_o  <= cmd_dat_i;
                log_rdat_o  <= rdat;
            end
        end
    end

endmodule

// File: design/rate_servo_top.sv
`timescale 1ns/100ps

module rate_servo_top #(
    parameter int NBEAMS       = 2,
    parameter int START_THRESH = 3500,
    parameter int TARGET_COUNT = 100,
    parameter int COUNT_MARGIN = 10,
    parameter int KP_STEP      = 1,
    parameter int BOOT_CYCLES  = 31,
    localparam int IDX_W       = (NBEAMS > 1) ? $clog2(NBEAMS) : 1
) (
    input  logic                         wb_clk_i,
    input  logic                         reset_i,
    // Upstream register bus
    input  logic                         wb_cyc_i,
    input  logic                         wb_stb_i,
    input  logic                         wb_we_i,
    input  logic [servo_pkg::ADDR_W-1:0] wb_adr_i,
    input  logic [servo_pkg::DATA_W-1:0] wb_dat_i,   // No writable registers behind it
    output logic                         wb_ack_o,
    output logic [servo_pkg::DATA_W-1:0] wb_dat_o,
    // Command bus to the trigger
    output logic                         cmd_cyc_o,
    output logic                         cmd_we_o,
    output logic [servo_pkg::ADDR_W-1:0] cmd_adr_o,
    output logic [servo_pkg::DATA_W-1:0] cmd_dat_o,
    input  logic                         cmd_ack_i,
    input  logic [servo_pkg::DATA_W-1:0] cmd_dat_i
);
    import servo_pkg::*;

    // Sequencer to master
    logic                req, req_we, busy, done;
    logic [ADDR_W-1:0]   req_adr;
    logic [DATA_W-1:0]   req_dat, rsp_dat;
    // Sequencer to bank
    logic [IDX_W-1:0]    seq_idx;
    logic                count_wr, calc, commit;
    logic [THRESH_W-1:0] pend_thresh;
    // Reg port to bank
    logic [IDX_W-1:0]    rd_idx;
    logic [DATA_W-1:0]   rd_count;
    logic [THRESH_W-1:0] rd_thresh;

    servo_reg_port #(.NBEAMS(NBEAMS), .KP_STEP(KP_STEP)) u_reg_port (
        .wb_clk_i, .reset_i,
        .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i,
        .wb_ack_o, .wb_dat_o,
        .rd_idx_o(rd_idx), .rd_count_i(rd_count), .rd_thresh_i(rd_thresh)
    );

    trig_cmd_master u_cmd_master (
        .wb_clk_i, .reset_i,
        .req_i(req), .req_we_i(req_we), .req_adr_i(req_adr), .req_dat_i(req_dat),
        .busy_o(busy), .done_o(done), .rsp_dat_o(rsp_dat),
        .cmd_cyc_o, .cmd_we_o, .cmd_adr_o, .cmd_dat_o, .cmd_ack_i, .cmd_dat_i
    );

    beam_bank #(
        .NBEAMS(NBEAMS), .START_THRESH(START_THRESH), .TARGET_COUNT(TARGET_COUNT),
        .COUNT_MARGIN(COUNT_MARGIN), .KP_STEP(KP_STEP)
    ) u_bank (
        .wb_clk_i, .reset_i,
        .seq_idx_i(seq_idx), .count_wr_i(count_wr), .count_dat_i(rsp_dat),
        .calc_i(calc), .commit_i(commit), .pend_thresh_o(pend_thresh),
        .rd_idx_i(rd_idx), .rd_count_o(rd_count), .rd_thresh_o(rd_thresh)
    );

    servo_sequencer #(.NBEAMS(NBEAMS), .BOOT_CYCLES(BOOT_CYCLES)) u_sequencer (
        .wb_clk_i, .reset_i,
        .req_o(req), .req_we_o(req_we), .req_adr_o(req_adr), .req_dat_o(req_dat),
        .busy_i(busy), .done_i(done), .rsp_dat_i(rsp_dat),
        .seq_idx_o(seq_idx), .count_wr_o(count_wr), .calc_o(calc), .commit_o(commit),
        .pend_thresh_i(pend_thresh)
    );

endmodule

// File: design/servo_sequencer.sv
`timescale 1ns/100ps

module servo_sequencer #(
    parameter int NBEAMS      = 2,
    parameter int BOOT_CYCLES = 31,
    localparam int IDX_W      = (NBEAMS > 1) ? $clog2(NBEAMS) : 1
) (
    input  logic                           wb_clk_i,
    input  logic                           reset_i,
    // Bus master requests
    output logic                           req_o,
    output logic                           req_we_o,
    output logic [servo_pkg::ADDR_W-1:0]   req_adr_o,
    output logic [servo_pkg::DATA_W-1:0]   req_dat_o,
    input  logic                           busy_i,
    input  logic                           done_i,
    input  logic [servo_pkg::DATA_W-1:0]   rsp_dat_i,
    // Beam bank strobes
    output logic [IDX_W-1:0]               seq_idx_o,
    output logic                           count_wr_o,
    output logic                           calc_o,
    output logic                           commit_o,
    input  logic [servo_pkg::THRESH_W-1:0] pend_thresh_i
);
    import servo_pkg::*;

    localparam int BOOT_W = (BOOT_CYCLES > 0) ? $clog2(BOOT_CYCLES + 1) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NBEAMS - 1);

    seq_state_e        state;
    logic [BOOT_W-1:0] boot_cnt;   // Counts down to zero
    logic [IDX_W-1:0]  idx;        // Beam in work
    logic              pending;    // Request issued, done not yet seen
    logic              bus_state;  // State drives a bus transaction
    logic              last_beam;

    assign bus_state  = (state != SEQ_BOOT) && (state != SEQ_CALC);
    assign last_beam  = (idx == LAST_IDX);
    assign req_o      = bus_state && !pending && !busy_i;
    assign seq_idx_o  = idx;
    assign count_wr_o = (state == SEQ_READ) && done_i;     // Response is this beam's count
    assign calc_o     = (state == SEQ_CALC);
    assign commit_o   = (state == SEQ_COMMIT) && done_i;   // Trigger took the commit

    ////////////////////////////////////////
    // Request contents per state
    ////////////////////////////////////////
    always_comb begin
        req_we_o  = 1'b1;
        req_adr_o = CMD_ADDR_CONTROL;
        req_dat_o = CTRL_START;
        case (state)
            SEQ_WAIT: req_we_o = 1'b0;   // Status read
            SEQ_READ: begin
                req_we_o  = 1'b0;
                req_adr_o = CMD_BASE_THRESH + ADDR_W'(idx);
            end
            SEQ_WRITE: begin
                req_adr_o = CMD_BASE_THRESH + ADDR_W'(idx);
                req_dat_o = DATA_W'(pend_thresh_i);
            end
            SEQ_LOAD: begin
                req_adr_o = CMD_BASE_LOAD + ADDR_W'(idx);
                req_dat_o = LOAD_ENABLE;
            end
            SEQ_COMMIT: req_dat_o = CTRL_COMMIT;
            default: ;   // Poll uses the start write
        endcase
    end

    ////////////////////////////////////////
    // Servo loop
    ////////////////////////////////////////
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state    <= SEQ_BOOT;
            boot_cnt <= BOOT_W'(BOOT_CYCLES);
            idx      <= '0;
            pending  <= 1'b0;
        end else begin
            if (req_o) pending <= 1'b1;
            case (state)
                SEQ_BOOT: begin
                    if (boot_cnt != '0) boot_cnt <= boot_cnt - 1'b1;
                    else state <= SEQ_WRITE;   // Push start thresholds first
                end
                SEQ_CALC: begin   // One beam per cycle, no bus traffic
                    idx <= last_beam ? '0 : idx + 1'b1;
                    if (last_beam) state <= SEQ_WRITE;
                end
                default: begin
                    if (pending && done_i) begin
                        pending <= 1'b0;
                        case (state)
                            SEQ_POLL: state <= SEQ_WAIT;
                            SEQ_WAIT: if (rsp_dat_i[0]) state <= SEQ_READ;   // Count done
                            SEQ_READ: begin
                                idx <= last_beam ? '0 : idx + 1'b1;
                                if (last_beam) state <= SEQ_CALC;
                            end
                            SEQ_WRITE: begin
                                idx <= last_beam ? '0 : idx + 1'b1;
                                if (last_beam) state <= SEQ_LOAD;
                            end
                            SEQ_LOAD: begin
                                idx <= last_beam ? '0 : idx + 1'b1;
                                if (last_beam) state <= SEQ_COMMIT;
                            end
                            default: state <= SEQ_POLL;   // Commit done, next period
                        endcase
                    end
                end
            endcase
        end
    end

endmodule

// File: design/beam_bank.sv
`timescale 1ns/100ps

module beam_bank #(
    parameter int NBEAMS       = 2,
    parameter int START_THRESH = 3500,
    parameter int TARGET_COUNT = 100,
    parameter int COUNT_MARGIN = 10,
    parameter int KP_STEP      = 1,
    localparam int IDX_W       = (NBEAMS > 1) ? $clog2(NBEAMS) : 1
) (
    input  logic                           wb_clk_i,
    input  logic                           reset_i,
    // Sequencer side
    input  logic [IDX_W-1:0]               seq_idx_i,
    input  logic                           count_wr_i,
    input  logic [servo_pkg::DATA_W-1:0]   count_dat_i,
    input  logic                           calc_i,
    input  logic                           commit_i,
    output logic [servo_pkg::THRESH_W-1:0] pend_thresh_o,
    // Readback side
    input  logic [IDX_W-1:0]               rd_idx_i,
    output logic [servo_pkg::DATA_W-1:0]   rd_count_o,
    output logic [servo_pkg::THRESH_W-1:0] rd_thresh_o
);
    import servo_pkg::*;

    // Dead band edges, a count on an edge leaves the threshold alone
    localparam logic [DATA_W-1:0]   HI_LIMIT = DATA_W'(TARGET_COUNT + COUNT_MARGIN);
    localparam logic [DATA_W-1:0]   LO_LIMIT = DATA_W'(TARGET_COUNT - COUNT_MARGIN);
    localparam logic [THRESH_W-1:0] STEP     = THRESH_W'(KP_STEP);
    localparam logic [THRESH_W-1:0] INIT_TH  = THRESH_W'(START_THRESH);

    logic [DATA_W-1:0]   count_q [NBEAMS];   // Last measured counts
    logic [THRESH_W-1:0] act_q   [NBEAMS];   // Thresholds in force
    logic [THRESH_W-1:0] pend_q  [NBEAMS];   // Next thresholds, committed together

    ////////////////////////////////////////
    // Count store, step rule, commit
    ////////////////////////////////////////
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            for (int b = 0; b < NBEAMS; b++) begin
                count_q[b] <= '0;
                act_q[b]   <= INIT_TH;
                pend_q[b]  <= INIT_TH;
            end
        end else begin
            if (count_wr_i) count_q[seq_idx_i] <= count_dat_i;
            if (calc_i) begin
                if (count_q[seq_idx_i] > HI_LIMIT) begin
                    pend_q[seq_idx_i] <= act_q[seq_idx_i] + STEP;   // Too many triggers, raise
                end else if (count_q[seq_idx_i] < LO_LIMIT) begin
                    pend_q[seq_idx_i] <= act_q[seq_idx_i] - STEP;   // Too few, lower
                end else begin
                    pend_q[seq_idx_i] <= act_q[seq_idx_i];          // Inside band
                end
            end
            if (commit_i) act_q <= pend_q;   // All beams at once
        end
    end

    assign pend_thresh_o = pend_q[seq_idx_i];
    assign rd_count_o    = count_q[rd_idx_i];
    assign rd_thresh_o   = act_q[rd_idx_i];

    // Sequencer beam index stays in range whenever it is used
    a_idx_range : assert property (@(posedge wb_clk_i) disable iff (reset_i)
        (count_wr_i || calc_i || commit_i) |-> (int'(seq_idx_i) < NBEAMS));

endmodule

// File: design/trig_cmd_master.sv
`timescale 1ns/100ps

module trig_cmd_master (
    input  logic                         wb_clk_i,
    input  logic                         reset_i,
    // Request side, from the sequencer
    input  logic                         req_i,
    input  logic                         req_we_i,
    input  logic [servo_pkg::ADDR_W-1:0] req_adr_i,
    input  logic [servo_pkg::DATA_W-1:0] req_dat_i,
    output logic                         busy_o,
    output logic                         done_o,
    output logic [servo_pkg::DATA_W-1:0] rsp_dat_o,
    // Command bus to the trigger registers
    output logic                         cmd_cyc_o,   // cyc and stb together
    output logic                         cmd_we_o,
    output logic [servo_pkg::ADDR_W-1:0] cmd_adr_o,
    output logic [servo_pkg::DATA_W-1:0] cmd_dat_o,
    input  logic                         cmd_ack_i,
    input  logic [servo_pkg::DATA_W-1:0] cmd_dat_i
);
    import servo_pkg::*;

    logic start;    // New request accepted this cycle
    logic finish;   // Trigger acked this cycle

    assign start  = req_i && !cmd_cyc_o;
    assign finish = cmd_cyc_o && cmd_ack_i;
    assign busy_o = cmd_cyc_o;

    // Control flags
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            cmd_cyc_o <= 1'b0;
            cmd_we_o  <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            done_o <= finish;   // One-cycle pulse after ack
            if (start) begin
                cmd_cyc_o <= 1'b1;
                cmd_we_o  <= req_we_i;
            end else if (finish) begin
                cmd_cyc_o <= 1'b0;   // Low at least one cycle before the next one
                cmd_we_o  <= 1'b0;
            end
        end
    end

    // Address and data held from cyc rise until ack
    always_ff @(posedge wb_clk_i) begin
        if (start) begin
            cmd_adr_o <= req_adr_i;
            cmd_dat_o <= req_dat_i;
        end
        if (finish) rsp_dat_o <= cmd_dat_i;   // Read data, meaningless on writes
    end

    // Sequencer must wait for the previous transaction to end
    a_no_req_busy : assert property (@(posedge wb_clk_i) disable iff (reset_i)
        req_i |-> !busy_o);

endmodule

// File: design/servo_reg_port.sv
`timescale 1ns/100ps

module servo_reg_port #(
    parameter int NBEAMS  = 2,
    parameter int KP_STEP = 1,
    localparam int IDX_W  = (NBEAMS > 1) ? $clog2(NBEAMS) : 1
) (
    input  logic                          wb_clk_i,
    input  logic                          reset_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  logic [servo_pkg::ADDR_W-1:0]  wb_adr_i,
    output logic                          wb_ack_o,
    output logic [servo_pkg::DATA_W-1:0]  wb_dat_o,
    output logic [IDX_W-1:0]              rd_idx_o,    // Beam being read back
    input  logic [servo_pkg::DATA_W-1:0]  rd_count_i,
    input  logic [servo_pkg::THRESH_W-1:0] rd_thresh_i
);
    import servo_pkg::*;

    port_state_e       state;
    logic [DATA_W-1:0] resp_q;   // Word returned with ack
    logic              idx_ok;   // Index names an existing beam

    assign rd_idx_o = wb_adr_i[IDX_W-1:0];
    assign idx_ok   = (int'(wb_adr_i[7:0]) < NBEAMS);

    ////////////////////////////////////////
    // Ack machine with fixed two-cycle latency
    ////////////////////////////////////////
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state <= PORT_IDLE;
        end else begin
            case (state)
                PORT_IDLE: begin
                    if (wb_cyc_i && wb_stb_i) begin
                        state <= wb_we_i ? PORT_WRITE : PORT_READ;
                    end
                end
                PORT_WRITE: state <= PORT_ACK;   // Nothing writable behind the port
                PORT_READ:  state <= PORT_ACK;
                default:    state <= PORT_IDLE;  // Ack lasts one cycle
            endcase
        end
    end

    // Readback word latched during the read cycle
    always_ff @(posedge wb_clk_i) begin
        if (state == PORT_READ) begin
            if (wb_adr_i[SEL_COUNT_BIT]) begin
                resp_q <= idx_ok ? rd_count_i : '0;             // Last count
            end else if (wb_adr_i[SEL_THRESH_BIT]) begin
                resp_q <= idx_ok ? DATA_W'(rd_thresh_i) : '0;   // Active threshold
            end else begin
                resp_q <= DATA_W'(KP_STEP);                     // Loop step
            end
        end
    end

    assign wb_ack_o = (state == PORT_ACK);
    assign wb_dat_o = resp_q;

    // Requester drops stb in the cycle after ack
    a_stb_drop : assert property (@(posedge wb_clk_i) disable iff (reset_i)
        wb_ack_o |=> !wb_stb_i);

endmodule

// File: design/servo_pkg.sv
package servo_pkg;

    ////////////////////////////////////////
    // Bus and threshold widths
    ////////////////////////////////////////
    localparam int DATA_W   = 32;   // Both buses
    localparam int ADDR_W   = 22;
    localparam int THRESH_W = 18;   // Trigger threshold field

    ////////////////////////////////////////
    // Trigger register map on the command bus
    ////////////////////////////////////////
    localparam logic [ADDR_W-1:0] CMD_ADDR_CONTROL = 22'h000000;  // Control write, status read
    localparam logic [ADDR_W-1:0] CMD_BASE_THRESH  = 22'h000100;  // Count read, threshold write
    localparam logic [ADDR_W-1:0] CMD_BASE_LOAD    = 22'h000200;  // Per-beam load enable

    // Values written to the control and load registers
    localparam logic [DATA_W-1:0] CTRL_START  = 32'h0000_0001;  // Begin a count period
    localparam logic [DATA_W-1:0] CTRL_COMMIT = 32'h0000_0002;  // Apply loaded thresholds
    localparam logic [DATA_W-1:0] LOAD_ENABLE = 32'h0000_0001;

    // Upstream readback select bits; beam index sits in bits 7:0
    localparam int SEL_COUNT_BIT  = 8;
    localparam int SEL_THRESH_BIT = 9;

    ////////////////////////////////////////
    // State encodings
    ////////////////////////////////////////
    typedef enum logic [1:0] {
        PORT_IDLE,
        PORT_WRITE,
        PORT_READ,
        PORT_ACK
    } port_state_e;

    typedef enum logic [2:0] {
        SEQ_BOOT,    // Power-up delay
        SEQ_POLL,    // Start a count period
        SEQ_WAIT,    // Read status until count done
        SEQ_READ,    // Fetch one count per beam
        SEQ_CALC,    // Step rule, one beam per cycle
        SEQ_WRITE,   // Send pending thresholds
        SEQ_LOAD,    // Load enable per beam
        SEQ_COMMIT   // Apply all at once
    } seq_state_e;

endpackage
